/* logic/mpf_pkg.sv */
// ----------------------------------------------------------------------------
// MPF shim package
// Widths, request encodings and parameter defaults shared by the shim
// ----------------------------------------------------------------------------

package mpf_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int ADDR_BITS  = 42;     // Line address
    localparam int MDATA_BITS = 16;     // Request tag returned with responses
    localparam int DATA_BITS  = 64;     // Reduced line payload

    // ------------------------------------------------------------------------
    // Header field types
    // ------------------------------------------------------------------------

    // Packet length in lines, encoded as length minus one
    typedef enum logic [1:0]
    {
        CL_LEN_1 = 2'd0,
        CL_LEN_2 = 2'd1,
        CL_LEN_4 = 2'd3
    } t_cl_len;

    typedef logic [1:0] t_cl_num;       // Beat index inside a packet

    // Read request types on c0
    typedef enum logic [1:0]
    {
        RD_LINE_I = 2'd0,               // No caching hint
        RD_LINE_S = 2'd1                // Cache in shared state
    } t_c0_req;

    // Write request types on c1
    typedef enum logic [1:0]
    {
        WR_LINE_I = 2'd0,
        WR_LINE_M = 2'd1,
        WR_FENCE  = 2'd2                // Ordering only, carries no data
    } t_c1_req;

    // Write header, 63 bits
    typedef struct packed
    {
        t_c1_req               req_type;
        logic                  sop;     // First beat of a packet
        t_cl_len               cl_len;
        logic [ADDR_BITS-1:0]  address;
        logic [MDATA_BITS-1:0] mdata;
    } t_c1_hdr;

    // ------------------------------------------------------------------------
    // Parameter defaults
    // ------------------------------------------------------------------------

    localparam bit DEF_REGISTER_INPUTS   = 1'b1;
    localparam bit DEF_REGISTER_OUTPUTS  = 1'b0;
    localparam bit DEF_CONVERT_TO_SINGLE = 1'b0;

    // A valid line write. Fences do not count
    function automatic logic c1_is_write_req(input logic valid, input t_c1_hdr hdr);
        return valid && ((hdr.req_type == WR_LINE_I) || (hdr.req_type == WR_LINE_M));
    endfunction

endpackage

/* logic/c1_tx_if.sv */
// ----------------------------------------------------------------------------
// Write request channel between the shim and the beat tracker
// ----------------------------------------------------------------------------

interface c1_tx_if;
    import mpf_pkg::*;

    logic                 valid;        // Beat strobe
    t_c1_hdr              hdr;
    logic [DATA_BITS-1:0] data;

    // Accelerator side of the tracker, sampled only
    modport afu
    (
        input valid,
        input hdr,
        input data
    );

    // Platform side of the tracker, driven with the rewritten beat
    modport fiu
    (
        output valid,
        output hdr,
        output data
    );

endinterface

/* logic/write_beat_tracker.sv */
// ----------------------------------------------------------------------------
// Write beat tracker
// Counts beats of multi-line writes and checks SOP phase, optionally
// splitting each beat into an independent single-line write
// ----------------------------------------------------------------------------

module write_beat_tracker
#(
    parameter bit CONVERT_TO_SINGLE = mpf_pkg::DEF_CONVERT_TO_SINGLE
)
(
    input  logic clk,
    input  logic reset,
    c1_tx_if.afu afu_tx,                // Raw request from the accelerator
    c1_tx_if.fiu fiu_tx                 // Request towards the platform
);
    import mpf_pkg::*;

    t_cl_num beat_num;                  // Index of the next expected beat
    logic    wr_req;

    assign wr_req = c1_is_write_req(afu_tx.valid, afu_tx.hdr);

    // ------------------------------------------------------------------------
    // Beat counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beat_num <= '0;
        end
        else if (wr_req)
        begin
            if (beat_num == t_cl_num'(afu_tx.hdr.cl_len))
            begin
                beat_num <= '0;         // Last beat closes the packet
            end
            else
            begin
                beat_num <= beat_num + t_cl_num'(1);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Forwarding
    // ------------------------------------------------------------------------

    assign fiu_tx.valid = afu_tx.valid;
    assign fiu_tx.data  = afu_tx.data;  // Payload never changes

    generate
        if (CONVERT_TO_SINGLE)
        begin : to_single
            always_comb
            begin
                fiu_tx.hdr = afu_tx.hdr;
                if (wr_req)
                begin
                    // Each beat becomes its own packet at its own line
                    fiu_tx.hdr.sop          = 1'b1;
                    fiu_tx.hdr.cl_len       = CL_LEN_1;
                    fiu_tx.hdr.address[1:0] = afu_tx.hdr.address[1:0] | beat_num;
                end
            end
        end
        else
        begin : keep_multi
            assign fiu_tx.hdr = afu_tx.hdr;   // Multi-line packets kept as issued
        end
    endgenerate

    // SOP must be set on the first beat of a packet and nowhere else
    sop_phase_a: assert property (@(posedge clk) disable iff (reset)
        wr_req |-> (afu_tx.hdr.sop == (beat_num == t_cl_num'(0))))
        else $error("write_beat_tracker: SOP out of phase");

    // Packet length may not shrink below the beats already taken
    len_hold_a: assert property (@(posedge clk) disable iff (reset)
        wr_req |-> (beat_num <= t_cl_num'(afu_tx.hdr.cl_len)))
        else $error("write_beat_tracker: beat count past packet length");

endmodule

/* logic/ccip_wires_to_fiu.sv */
// ----------------------------------------------------------------------------
// Platform wires to accelerator bus
// Registers soft reset, optionally registers responses and requests
// ----------------------------------------------------------------------------

module ccip_wires_to_fiu
#(
    parameter bit REGISTER_INPUTS   = mpf_pkg::DEF_REGISTER_INPUTS,
    parameter bit REGISTER_OUTPUTS  = mpf_pkg::DEF_REGISTER_OUTPUTS,
    parameter bit CONVERT_TO_SINGLE = mpf_pkg::DEF_CONVERT_TO_SINGLE
)
(
    input  logic                          clk,
    input  logic                          soft_reset,       // Platform reset, active high
    // Platform responses and flow control
    input  logic                          c0_rx_valid,
    input  logic [mpf_pkg::MDATA_BITS-1:0] c0_rx_mdata,
    input  logic [mpf_pkg::DATA_BITS-1:0]  c0_rx_data,
    input  logic                          c1_rx_valid,
    input  logic [mpf_pkg::MDATA_BITS-1:0] c1_rx_mdata,
    input  logic                          c0_almfull,
    input  logic                          c1_almfull,
    // Platform requests
    output logic                          c0_tx_valid,
    output mpf_pkg::t_c0_req              c0_tx_type,
    output logic [mpf_pkg::ADDR_BITS-1:0]  c0_tx_addr,
    output logic [mpf_pkg::MDATA_BITS-1:0] c0_tx_mdata,
    output logic                          c1_tx_valid,
    output mpf_pkg::t_c1_hdr              c1_tx_hdr,
    output logic [mpf_pkg::DATA_BITS-1:0]  c1_tx_data,
    // Accelerator side
    output logic                          fiu_reset,
    output logic                          fiu_c0_rx_valid,
    output logic [mpf_pkg::MDATA_BITS-1:0] fiu_c0_rx_mdata,
    output logic [mpf_pkg::DATA_BITS-1:0]  fiu_c0_rx_data,
    output logic                          fiu_c1_rx_valid,
    output logic [mpf_pkg::MDATA_BITS-1:0] fiu_c1_rx_mdata,
    output logic                          fiu_c0_almfull,
    output logic                          fiu_c1_almfull,
    input  logic                          fiu_c0_tx_valid,
    input  mpf_pkg::t_c0_req              fiu_c0_tx_type,
    input  logic [mpf_pkg::ADDR_BITS-1:0]  fiu_c0_tx_addr,
    input  logic [mpf_pkg::MDATA_BITS-1:0] fiu_c0_tx_mdata,
    input  logic                          fiu_c1_tx_valid,
    input  mpf_pkg::t_c1_hdr              fiu_c1_tx_hdr,
    input  logic [mpf_pkg::DATA_BITS-1:0]  fiu_c1_tx_data
);

    logic reset = 1'b1;                 // Held in reset until the platform releases it

    always_ff @(posedge clk)
    begin
        reset <= soft_reset;
    end

    assign fiu_reset = reset;

    // ------------------------------------------------------------------------
    // Write channel through the beat tracker
    // ------------------------------------------------------------------------

    c1_tx_if c1_raw ();                 // As issued by the accelerator
    c1_tx_if c1_trk ();                 // After beat tracking

    assign c1_raw.valid = fiu_c1_tx_valid;
    assign c1_raw.hdr   = fiu_c1_tx_hdr;
    assign c1_raw.data  = fiu_c1_tx_data;

    write_beat_tracker
    #(
        .CONVERT_TO_SINGLE (CONVERT_TO_SINGLE)
    )
    write_beat_tracker_i
    (
        .clk    (clk),
        .reset  (reset),
        .afu_tx (c1_raw.afu),
        .fiu_tx (c1_trk.fiu)
    );

    // ------------------------------------------------------------------------
    // Requests and almost-full towards the platform
    // ------------------------------------------------------------------------

    generate
        if (REGISTER_OUTPUTS)
        begin : reg_out
            always_ff @(posedge clk)
            begin
                if (reset)
                begin
                    c0_tx_valid <= 1'b0;
                    c1_tx_valid <= 1'b0;
                end
                else
                begin
                    c0_tx_valid <= fiu_c0_tx_valid;
                    c1_tx_valid <= c1_trk.valid;
                end
                c0_tx_type     <= fiu_c0_tx_type;
                c0_tx_addr     <= fiu_c0_tx_addr;
                c0_tx_mdata    <= fiu_c0_tx_mdata;
                c1_tx_hdr      <= c1_trk.hdr;
                c1_tx_data     <= c1_trk.data;
                fiu_c0_almfull <= c0_almfull;
                fiu_c1_almfull <= c1_almfull;
            end
        end
        else
        begin : wire_out
            always_comb
            begin
                c0_tx_valid    = fiu_c0_tx_valid;
                c0_tx_type     = fiu_c0_tx_type;
                c0_tx_addr     = fiu_c0_tx_addr;
                c0_tx_mdata    = fiu_c0_tx_mdata;
                c1_tx_valid    = c1_trk.valid;
                c1_tx_hdr      = c1_trk.hdr;
                c1_tx_data     = c1_trk.data;
                fiu_c0_almfull = c0_almfull;   // Level only, no stall here
                fiu_c1_almfull = c1_almfull;
            end
        end
    endgenerate

    // ------------------------------------------------------------------------
    // Responses towards the accelerator
    // ------------------------------------------------------------------------

    generate
        if (REGISTER_INPUTS)
        begin : reg_in
            always_ff @(posedge clk)
            begin
                if (reset)
                begin
                    fiu_c0_rx_valid <= 1'b0;
                    fiu_c1_rx_valid <= 1'b0;
                end
                else
                begin
                    fiu_c0_rx_valid <= c0_rx_valid;
                    fiu_c1_rx_valid <= c1_rx_valid;
                end
            end

            always_ff @(posedge clk)
            begin
                fiu_c0_rx_mdata <= c0_rx_mdata;
                fiu_c0_rx_data  <= c0_rx_data;
                fiu_c1_rx_mdata <= c1_rx_mdata;
            end
        end
        else
        begin : wire_in
            always_comb
            begin
                fiu_c0_rx_valid = c0_rx_valid;
                fiu_c0_rx_mdata = c0_rx_mdata;
                fiu_c0_rx_data  = c0_rx_data;
                fiu_c1_rx_valid = c1_rx_valid;
                fiu_c1_rx_mdata = c1_rx_mdata;
            end
        end
    endgenerate

endmodule

/* logic/mpf_shim_top.sv */
// ----------------------------------------------------------------------------
// MPF shim top level
// Platform and accelerator wires with multi-line write splitting enabled
// ----------------------------------------------------------------------------

module mpf_shim_top
(
    input  logic                          clk,
    input  logic                          soft_reset,
    // Platform responses and flow control
    input  logic                          c0_rx_valid,
    input  logic [mpf_pkg::MDATA_BITS-1:0] c0_rx_mdata,
    input  logic [mpf_pkg::DATA_BITS-1:0]  c0_rx_data,
    input  logic                          c1_rx_valid,
    input  logic [mpf_pkg::MDATA_BITS-1:0] c1_rx_mdata,
    input  logic                          c0_almfull,
    input  logic                          c1_almfull,
    // Platform requests
    output logic                          c0_tx_valid,
    output mpf_pkg::t_c0_req              c0_tx_type,
    output logic [mpf_pkg::ADDR_BITS-1:0]  c0_tx_addr,
    output logic [mpf_pkg::MDATA_BITS-1:0] c0_tx_mdata,
    output logic                          c1_tx_valid,
    output mpf_pkg::t_c1_hdr              c1_tx_hdr,
    output logic [mpf_pkg::DATA_BITS-1:0]  c1_tx_data,
    // Accelerator side
    output logic                          fiu_reset,
    output logic                          fiu_c0_rx_valid,
    output logic [mpf_pkg::MDATA_BITS-1:0] fiu_c0_rx_mdata,
    output logic [mpf_pkg::DATA_BITS-1:0]  fiu_c0_rx_data,
    output logic                          fiu_c1_rx_valid,
    output logic [mpf_pkg::MDATA_BITS-1:0] fiu_c1_rx_mdata,
    output logic                          fiu_c0_almfull,
    output logic                          fiu_c1_almfull,
    input  logic                          fiu_c0_tx_valid,
    input  mpf_pkg::t_c0_req              fiu_c0_tx_type,
    input  logic [mpf_pkg::ADDR_BITS-1:0]  fiu_c0_tx_addr,
    input  logic [mpf_pkg::MDATA_BITS-1:0] fiu_c0_tx_mdata,
    input  logic                          fiu_c1_tx_valid,
    input  mpf_pkg::t_c1_hdr              fiu_c1_tx_hdr,
    input  logic [mpf_pkg::DATA_BITS-1:0]  fiu_c1_tx_data
);

    // Debug build, every write beat leaves as its own single-line packet
    ccip_wires_to_fiu
    #(
        .REGISTER_INPUTS   (mpf_pkg::DEF_REGISTER_INPUTS),
        .REGISTER_OUTPUTS  (mpf_pkg::DEF_REGISTER_OUTPUTS),
        .CONVERT_TO_SINGLE (1'b1)
    )
    ccip_wires_to_fiu_i
    (
        .clk             (clk),
        .soft_reset      (soft_reset),
        .c0_rx_valid     (c0_rx_valid),
        .c0_rx_mdata     (c0_rx_mdata),
        .c0_rx_data      (c0_rx_data),
        .c1_rx_valid     (c1_rx_valid),
        .c1_rx_mdata     (c1_rx_mdata),
        .c0_almfull      (c0_almfull),
        .c1_almfull      (c1_almfull),
        .c0_tx_valid     (c0_tx_valid),
        .c0_tx_type      (c0_tx_type),
        .c0_tx_addr      (c0_tx_addr),
        .c0_tx_mdata     (c0_tx_mdata),
        .c1_tx_valid     (c1_tx_valid),
        .c1_tx_hdr       (c1_tx_hdr),
        .c1_tx_data      (c1_tx_data),
        .fiu_reset       (fiu_reset),
        .fiu_c0_rx_valid (fiu_c0_rx_valid),
        .fiu_c0_rx_mdata (fiu_c0_rx_mdata),
        .fiu_c0_rx_data  (fiu_c0_rx_data),
        .fiu_c1_rx_valid (fiu_c1_rx_valid),
        .fiu_c1_rx_mdata (fiu_c1_rx_mdata),
        .fiu_c0_almfull  (fiu_c0_almfull),
        .fiu_c1_almfull  (fiu_c1_almfull),
        .fiu_c0_tx_valid (fiu_c0_tx_valid),
        .fiu_c0_tx_type  (fiu_c0_tx_type),
        .fiu_c0_tx_addr  (fiu_c0_tx_addr),
        .fiu_c0_tx_mdata (fiu_c0_tx_mdata),
        .fiu_c1_tx_valid (fiu_c1_tx_valid),
        .fiu_c1_tx_hdr   (fiu_c1_tx_hdr),
        .fiu_c1_tx_data  (fiu_c1_tx_data)
    );

endmodule

/* include/tb_compare_tasks.svh */
// ----------------------------------------------------------------------------
// Compare tasks for shim results, reporting mismatches in hex
// ----------------------------------------------------------------------------

`ifndef TB_COMPARE_TASKS_SVH
`define TB_COMPARE_TASKS_SVH

task automatic check_c1_hdr(input string what, input mpf_pkg::t_c1_hdr got,
                            input mpf_pkg::t_c1_hdr exp);
    if (got !== exp)
    begin
        $display("MISMATCH %s: got %h expected %h", what, got, exp);
        $fatal(1, "c1 header mismatch");
    end
endtask

// Read request type and line address together
task automatic check_c0_req(input string what, input mpf_pkg::t_c0_req got_type,
                            input logic [mpf_pkg::ADDR_BITS-1:0] got_addr,
                            input mpf_pkg::t_c0_req exp_type,
                            input logic [mpf_pkg::ADDR_BITS-1:0] exp_addr);
    if ((got_type !== exp_type) || (got_addr !== exp_addr))
    begin
        $display("MISMATCH %s: got %h/%h expected %h/%h", what, got_type, got_addr,
                 exp_type, exp_addr);
        $fatal(1, "c0 request mismatch");
    end
endtask

task automatic check_data(input string what, input logic [mpf_pkg::MDATA_BITS-1:0] got_mdata,
                          input logic [mpf_pkg::DATA_BITS-1:0] got_data,
                          input logic [mpf_pkg::MDATA_BITS-1:0] exp_mdata,
                          input logic [mpf_pkg::DATA_BITS-1:0] exp_data);
    if ((got_mdata !== exp_mdata) || (got_data !== exp_data))
    begin
        $display("MISMATCH %s: got %h/%h expected %h/%h", what, got_mdata, got_data,
                 exp_mdata, exp_data);
        $fatal(1, "payload mismatch");
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("MISMATCH %s: got %h expected %h", what, got, exp);
        $fatal(1, "flag mismatch");
    end
endtask

`endif

/* verification/mpf_shim_tb.sv */
// ----------------------------------------------------------------------------
// MPF shim testbench
// Table-driven checks of reset, pass-through paths and write beat splitting
// ----------------------------------------------------------------------------

module mpf_shim_tb;
    import mpf_pkg::*;

    `include "tb_compare_tasks.svh"

    localparam int WAIT_LIMIT = 8;      // Cycles allowed for any level change

    // One row per cycle, rx fields are also the expected fiu rx one cycle later
    typedef struct packed
    {
        logic                  c0_valid;
        t_c0_req               c0_type;
        logic [ADDR_BITS-1:0]  c0_addr;
        logic [MDATA_BITS-1:0] c0_mdata;
        logic                  c1_valid;
        t_c1_hdr               c1_hdr;
        logic [DATA_BITS-1:0]  c1_data;
        logic                  rx0_valid;
        logic [MDATA_BITS-1:0] rx0_mdata;
        logic [DATA_BITS-1:0]  rx0_data;
        logic                  rx1_valid;
        logic [MDATA_BITS-1:0] rx1_mdata;
        logic                  af0;
        logic                  af1;
        t_c1_hdr               exp_hdr;  // Header expected at the platform
    } t_row;

    logic                  clk;
    logic                  soft_reset;
    logic                  c0_rx_valid;
    logic [MDATA_BITS-1:0] c0_rx_mdata;
    logic [DATA_BITS-1:0]  c0_rx_data;
    logic                  c1_rx_valid;
    logic [MDATA_BITS-1:0] c1_rx_mdata;
    logic                  c0_almfull;
    logic                  c1_almfull;
    logic                  c0_tx_valid;
    t_c0_req               c0_tx_type;
    logic [ADDR_BITS-1:0]  c0_tx_addr;
    logic [MDATA_BITS-1:0] c0_tx_mdata;
    logic                  c1_tx_valid;
    t_c1_hdr               c1_tx_hdr;
    logic [DATA_BITS-1:0]  c1_tx_data;
    logic                  fiu_reset;
    logic                  fiu_c0_rx_valid;
    logic [MDATA_BITS-1:0] fiu_c0_rx_mdata;
    logic [DATA_BITS-1:0]  fiu_c0_rx_data;
    logic                  fiu_c1_rx_valid;
    logic [MDATA_BITS-1:0] fiu_c1_rx_mdata;
    logic                  fiu_c0_almfull;
    logic                  fiu_c1_almfull;
    logic                  fiu_c0_tx_valid;
    t_c0_req               fiu_c0_tx_type;
    logic [ADDR_BITS-1:0]  fiu_c0_tx_addr;
    logic [MDATA_BITS-1:0] fiu_c0_tx_mdata;
    logic                  fiu_c1_tx_valid;
    t_c1_hdr               fiu_c1_tx_hdr;
    logic [DATA_BITS-1:0]  fiu_c1_tx_data;

    t_row        rows[$];
    logic [31:0] lcg_state = 32'd50593;

    mpf_shim_top mpf_shim_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Random payloads and table rows
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [MDATA_BITS-1:0] draw_mdata();
        logic [31:0] v;
        v = lcg_next();
        return v[31:16];                // Upper bits are the better ones
    endfunction

    function automatic logic [DATA_BITS-1:0] draw_data();
        return {lcg_next(), lcg_next()};
    endfunction

    // Nothing valid, random payloads that must not matter
    function automatic t_row blank_row();
        t_row r;
        r = '0;
        r.c0_mdata     = draw_mdata();
        r.c1_hdr.mdata = draw_mdata();
        r.c1_data      = draw_data();
        r.rx0_mdata    = draw_mdata();
        r.rx0_data     = draw_data();
        r.rx1_mdata    = draw_mdata();
        r.exp_hdr      = r.c1_hdr;      // Non-writes pass unchanged
        return r;
    endfunction

    // Beat of a line write, leaving as its own single-line packet
    function automatic t_row write_row(input t_c1_req kind, input logic sop,
                                       input t_cl_len len, input logic [ADDR_BITS-1:0] base,
                                       input t_cl_num beat);
        t_row r;
        r = blank_row();
        r.c1_valid          = 1'b1;
        r.c1_hdr.req_type   = kind;
        r.c1_hdr.sop        = sop;
        r.c1_hdr.cl_len     = len;
        r.c1_hdr.address    = base;     // Same base on every beat
        r.exp_hdr           = r.c1_hdr;
        r.exp_hdr.sop       = 1'b1;
        r.exp_hdr.cl_len    = CL_LEN_1;
        r.exp_hdr.address   = base + ADDR_BITS'(beat);
        return r;
    endfunction

    task automatic build_table();
        t_row r;
        r = blank_row();                // Read with c0 almost-full
        r.c0_valid = 1'b1;
        r.c0_type  = RD_LINE_S;
        r.c0_addr  = 42'h12_3456_789A;
        r.af0      = 1'b1;
        rows.push_back(r);
        r = blank_row();                // Read plus both responses
        r.c0_valid  = 1'b1;
        r.c0_type   = RD_LINE_I;
        r.c0_addr   = 42'h01_0000_0040;
        r.af1       = 1'b1;
        r.rx0_valid = 1'b1;
        r.rx1_valid = 1'b1;
        rows.push_back(r);
        r = blank_row();
        r.rx0_valid = 1'b1;             // Back-to-back read response
        rows.push_back(r);
        for (int b = 0; b < 4; b++)
        begin
            rows.push_back(write_row(WR_LINE_I, b == 0, CL_LEN_4, 42'hAB_CDEF_0120,
                                     t_cl_num'(b)));
        end
        // ---------------- mixed sequence --------------------------------------
        rows.push_back(write_row(WR_LINE_M, 1'b1, CL_LEN_1, 42'h00_0000_1003, 2'd0));
        rows.push_back(blank_row());
        rows.push_back(write_row(WR_LINE_I, 1'b1, CL_LEN_2, 42'h00_0000_2002, 2'd0));
        rows.push_back(blank_row());    // Idle inside a packet, count holds
        rows.push_back(write_row(WR_LINE_I, 1'b0, CL_LEN_2, 42'h00_0000_2002, 2'd1));
        r = blank_row();
        r.c1_valid          = 1'b1;
        r.c1_hdr.req_type   = WR_FENCE;
        r.exp_hdr           = r.c1_hdr;
        rows.push_back(r);
        rows.push_back(write_row(WR_LINE_M, 1'b1, CL_LEN_1, 42'h00_0000_3001, 2'd0));
        r = write_row(WR_LINE_I, 1'b1, CL_LEN_2, 42'h00_0000_4000, 2'd0);
        r.rx1_valid = 1'b1;             // Write response alongside
        rows.push_back(r);
        rows.push_back(write_row(WR_LINE_I, 1'b0, CL_LEN_2, 42'h00_0000_4000, 2'd1));
        rows.push_back(blank_row());
    endtask

    task automatic drive_row(input t_row r);
        fiu_c0_tx_valid = r.c0_valid;
        fiu_c0_tx_type  = r.c0_type;
        fiu_c0_tx_addr  = r.c0_addr;
        fiu_c0_tx_mdata = r.c0_mdata;
        fiu_c1_tx_valid = r.c1_valid;
        fiu_c1_tx_hdr   = r.c1_hdr;
        fiu_c1_tx_data  = r.c1_data;
        c0_rx_valid     = r.rx0_valid;
        c0_rx_mdata     = r.rx0_mdata;
        c0_rx_data      = r.rx0_data;
        c1_rx_valid     = r.rx1_valid;
        c1_rx_mdata     = r.rx1_mdata;
        c0_almfull      = r.af0;
        c1_almfull      = r.af1;
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    task automatic announce_failure();
        $display("Done: errors found");
    endtask

    task automatic hdr_must_match(input string what, input t_c1_hdr got, input t_c1_hdr exp);
        if (got !== exp)
            announce_failure();
        check_c1_hdr(what, got, exp);
    endtask

    task automatic read_must_match(input string what, input t_c0_req got_type,
                                   input logic [ADDR_BITS-1:0] got_addr,
                                   input t_c0_req exp_type,
                                   input logic [ADDR_BITS-1:0] exp_addr);
        if ((got_type !== exp_type) || (got_addr !== exp_addr))
            announce_failure();
        check_c0_req(what, got_type, got_addr, exp_type, exp_addr);
    endtask

    task automatic payload_must_match(input string what, input logic [MDATA_BITS-1:0] got_m,
                                      input logic [DATA_BITS-1:0] got_d,
                                      input logic [MDATA_BITS-1:0] exp_m,
                                      input logic [DATA_BITS-1:0] exp_d);
        if ((got_m !== exp_m) || (got_d !== exp_d))
            announce_failure();
        check_data(what, got_m, got_d, exp_m, exp_d);
    endtask

    task automatic flag_must_match(input string what, input logic got, input logic exp);
        if (got !== exp)
            announce_failure();
        check_flag(what, got, exp);
    endtask

    task automatic latency_must_be_one(input string what, input int cycles);
        if (cycles != 1)
        begin
            $display("MISMATCH %s latency: got %h expected %h", what, cycles, 1);
            announce_failure();
            $fatal(1, "reset latency wrong");
        end
    endtask

    // Bounded wait on negedges until fiu_reset reaches the level
    task automatic await_fiu_reset(input logic level, output int cycles);
        cycles = 0;
        while (fiu_reset !== level)
        begin
            if (cycles >= WAIT_LIMIT)
            begin
                $display("Timeout: fiu_reset never reached %0b", level);
                announce_failure();
                $fatal(1, "timeout");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Same-cycle paths, sampled mid low phase
    task automatic check_tx(input t_row r);
        flag_must_match("c0_tx_valid", c0_tx_valid, r.c0_valid);
        read_must_match("c0_tx", c0_tx_type, c0_tx_addr, r.c0_type, r.c0_addr);
        payload_must_match("c0_tx_mdata", c0_tx_mdata, '0, r.c0_mdata, '0);
        flag_must_match("c1_tx_valid", c1_tx_valid, r.c1_valid);
        hdr_must_match("c1_tx_hdr", c1_tx_hdr, r.exp_hdr);
        payload_must_match("c1_tx_data", '0, c1_tx_data, '0, r.c1_data);
        flag_must_match("fiu_c0_almfull", fiu_c0_almfull, r.af0);
        flag_must_match("fiu_c1_almfull", fiu_c1_almfull, r.af1);
        flag_must_match("fiu_reset", fiu_reset, 1'b0);
    endtask

    // Responses one cycle after they were driven
    task automatic check_rx(input t_row r);
        flag_must_match("fiu_c0_rx_valid", fiu_c0_rx_valid, r.rx0_valid);
        payload_must_match("fiu_c0_rx", fiu_c0_rx_mdata, fiu_c0_rx_data, r.rx0_mdata,
                           r.rx0_data);
        flag_must_match("fiu_c1_rx_valid", fiu_c1_rx_valid, r.rx1_valid);
        payload_must_match("fiu_c1_rx_mdata", fiu_c1_rx_mdata, '0, r.rx1_mdata, '0);
    endtask

    task automatic check_rx_quiet();
        flag_must_match("fiu_c0_rx_valid", fiu_c0_rx_valid, 1'b0);
        flag_must_match("fiu_c1_rx_valid", fiu_c1_rx_valid, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial
    begin
        t_row idle;
        int   n;
        idle = '0;
        soft_reset = 1'b1;
        drive_row(idle);
        c0_rx_valid = 1'b1;             // Must stay hidden by reset
        c1_rx_valid = 1'b1;
        build_table();
        repeat (4)
        begin
            @(negedge clk);
            flag_must_match("fiu_reset", fiu_reset, 1'b1);
            check_rx_quiet();
        end
        soft_reset = 1'b0;
        drive_row(idle);
        await_fiu_reset(1'b0, n);
        latency_must_be_one("fiu_reset fall", n);

        for (int k = 0; k < rows.size(); k++)
        begin
            @(negedge clk);
            if (k > 0)
                check_rx(rows[k-1]);
            drive_row(rows[k]);
            #5;                         // Let combinational paths settle
            check_tx(rows[k]);
        end
        @(negedge clk);
        check_rx(rows[rows.size()-1]);

        // Reset again between packets, responses offered while held
        drive_row(idle);
        soft_reset = 1'b1;
        await_fiu_reset(1'b1, n);
        latency_must_be_one("fiu_reset rise", n);
        c0_rx_valid = 1'b1;
        c1_rx_valid = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            flag_must_match("fiu_reset", fiu_reset, 1'b1);
            check_rx_quiet();
        end
        soft_reset  = 1'b0;
        c0_rx_valid = 1'b0;
        c1_rx_valid = 1'b0;
        await_fiu_reset(1'b0, n);
        latency_must_be_one("fiu_reset fall", n);
        check_rx_quiet();

        $display("Done: no errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
logic/mpf_pkg.sv
logic/c1_tx_if.sv
logic/write_beat_tracker.sv
logic/ccip_wires_to_fiu.sv
logic/mpf_shim_top.sv
verification/mpf_shim_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mpf_shim_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
